/* project.f */
dispatch_pkg.sv
phys_regfile.sv
dispatch_buffer.sv
issue_stage.sv
dispatch_top.sv
tb_dispatch_top.sv

/* Makefile */
# Verilator build and run of the dispatch front testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f project.f \
		--top-module tb_dispatch_top -o tb_dispatch_top
	./obj_dir/tb_dispatch_top | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_dispatch_top.sv */
/*
  Testbench for the dispatch front. Plays fetch and the execution side from a
  table of cases and checks the issue outputs against a register model.
*/

`timescale 1ns/1ns

module tb_dispatch_top;

  localparam int NUM_PREGS = 64;
  localparam int IDX_W     = $clog2(NUM_PREGS);
  localparam int NUM_CASES = 8;
  localparam int TIMEOUT   = 20;  // Cycles allowed per wait

  typedef struct packed {
    dispatch_pkg::inst_word_t ir;
    dispatch_pkg::npc_t       npc;
    logic [IDX_W-1:0]         pdest;
    logic [IDX_W-1:0]         ra;
    logic [IDX_W-1:0]         rb;
    dispatch_pkg::alu_func_t  alu;
    logic                     rd;
    logic                     wr;
  } inst_t;

  logic clock;
  logic arst_n;
  logic flush;
  logic in_req;
  logic in_ack;
  logic [1:0]                       in_valid;
  dispatch_pkg::inst_word_t [1:0]   in_ir;
  dispatch_pkg::npc_t [1:0]         in_npc;
  logic [1:0][IDX_W-1:0]            in_pdest;
  logic [1:0][IDX_W-1:0]            in_prega;
  logic [1:0][IDX_W-1:0]            in_pregb;
  dispatch_pkg::alu_func_t [1:0]    in_alu_func;
  logic [1:0]                       in_rd_mem;
  logic [1:0]                       in_wr_mem;
  dispatch_pkg::free_count_t        window_free;
  logic [1:0]                       wb_valid;
  logic [1:0][IDX_W-1:0]            wb_tag;
  dispatch_pkg::word_t [1:0]        wb_value;
  logic [1:0]                       iss_valid;
  dispatch_pkg::inst_word_t [1:0]   iss_ir;
  dispatch_pkg::npc_t [1:0]         iss_npc;
  logic [1:0][IDX_W-1:0]            iss_pdest;
  dispatch_pkg::alu_func_t [1:0]    iss_alu_func;
  logic [1:0]                       iss_rd_mem;
  logic [1:0]                       iss_wr_mem;
  dispatch_pkg::word_t [1:0]        iss_rega_value;
  dispatch_pkg::word_t [1:0]        iss_regb_value;

  //////////////////////////////////////////////////
  // Case table
  //////////////////////////////////////////////////

  // Columns: valid, a0, b0, a1, b1, preload tag x2, window_free x4, wb_valid,
  // wb_tag x2, wb cycle, flush cycle, second request cycle (7 is never)
  int tab [NUM_CASES][17] = '{
    '{3, 1, 2, 3, 0, 1, 2, 2, 2, 2, 2, 0, 0, 0, 7, 7, 7},
    '{3, 2, 3, 1, 2, 3, 0, 1, 1, 2, 2, 0, 0, 0, 7, 7, 7},
    '{3, 4, 5, 6, 1, 4, 5, 0, 0, 2, 2, 0, 0, 0, 7, 7, 1},
    '{3, 7, 8, 8, 7, 7, 8, 2, 2, 2, 2, 3, 8, 8, 0, 7, 7},
    '{3, 0, 8, 9, 0, 0, 0, 1, 1, 2, 2, 3, 0, 9, 0, 7, 7},
    '{3, 1, 2, 3, 4, 0, 0, 1, 1, 2, 2, 0, 0, 0, 7, 1, 7},
    '{1, 5, 6, 0, 0, 6, 0, 2, 2, 2, 2, 0, 0, 0, 7, 7, 7},
    '{0, 1, 1, 1, 1, 0, 0, 2, 2, 2, 2, 0, 0, 0, 7, 7, 7}
  };
  string case_name [NUM_CASES] = '{"pair_free2", "pair_free1", "stall_and_hold_req",
    "fwd_same_tag", "fwd_zero_reg", "flush_pending", "single_after_flush", "empty_pair"};

  integer seed;
  int mismatches;
  int timeouts;
  string case_label;
  dispatch_pkg::word_t model_reg [NUM_PREGS];  // Reference register file
  inst_t pend [2];                             // Model of the two slots, oldest first
  int pend_cnt;
  inst_t drv [2];                              // Pair on the fetch side
  logic exp_ack;
  logic [1:0] exp_valid;
  inst_t exp_inst [2];
  dispatch_pkg::word_t exp_a [2];
  dispatch_pkg::word_t exp_b [2];

  dispatch_top #(.NUM_PREGS(NUM_PREGS)) i_dispatch_top (.*);

  initial
  begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  //////////////////////////////////////////////////
  // Model and checks
  //////////////////////////////////////////////////

  function automatic dispatch_pkg::word_t forward(logic [IDX_W-1:0] idx);
    dispatch_pkg::word_t v;
    v = model_reg[idx];
    for (int p = 0; p < 2; p++)
    begin
      if (wb_valid[p] && wb_tag[p] == idx && idx != '0)
        v = wb_value[p];  // Port 1 last
    end
    return v;
  endfunction

  task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
    assert (actual === expected)
    else
    begin
      mismatches++;
      $display("mismatch %s %s: expected %0h, actual %0h", case_label, what, expected, actual);
    end
  endtask

  // Next edge, then compare outputs with what the model predicted
  task automatic tick();
    @(posedge clock);
    #1;
    check_value("in_ack", 64'(exp_ack), 64'(in_ack));
    check_value("iss_valid", 64'(exp_valid), 64'(iss_valid));
    for (int j = 0; j < 2; j++)
    begin
      if (exp_valid[j])
      begin
        check_value($sformatf("iss_ir[%0d]", j), 64'(exp_inst[j].ir), 64'(iss_ir[j]));
        check_value($sformatf("iss_npc[%0d]", j), exp_inst[j].npc, iss_npc[j]);
        check_value($sformatf("iss_pdest[%0d]", j), 64'(exp_inst[j].pdest), 64'(iss_pdest[j]));
        check_value($sformatf("iss_alu_func[%0d]", j), 64'(exp_inst[j].alu),
          64'(iss_alu_func[j]));
        check_value($sformatf("iss_rd_mem[%0d]", j), 64'(exp_inst[j].rd), 64'(iss_rd_mem[j]));
        check_value($sformatf("iss_wr_mem[%0d]", j), 64'(exp_inst[j].wr), 64'(iss_wr_mem[j]));
        check_value($sformatf("iss_rega_value[%0d]", j), exp_a[j], iss_rega_value[j]);
        check_value($sformatf("iss_regb_value[%0d]", j), exp_b[j], iss_regb_value[j]);
      end
    end
  endtask

  // Predicts the next edge from the inputs now driven
  task automatic model_cycle();
    int n;
    logic capture;
    n = (pend_cnt < int'(window_free)) ? pend_cnt : int'(window_free);
    for (int j = 0; j < 2; j++)
    begin
      exp_valid[j] = (j < n) && !flush;
      if (j < n)
      begin
        exp_inst[j] = pend[j];
        exp_a[j]    = forward(pend[j].ra);
        exp_b[j]    = forward(pend[j].rb);
      end
    end
    capture = in_req && !exp_ack && pend_cnt == 0;
    if (capture)
      exp_ack = 1'b1;
    else if (!in_req)
      exp_ack = 1'b0;
    if (flush)
      pend_cnt = 0;
    else if (capture)
    begin
      pend_cnt = 0;
      for (int s = 0; s < 2; s++)
      begin
        if (in_valid[s])
        begin
          pend[pend_cnt] = drv[s];
          pend_cnt++;
        end
      end
    end
    else
    begin
      if (n == 1)
        pend[0] = pend[1];  // Younger moves down
      pend_cnt = pend_cnt - n;
    end
    for (int p = 0; p < 2; p++)
    begin
      if (wb_valid[p] && wb_tag[p] != '0)
        model_reg[wb_tag[p]] = wb_value[p];
    end
  endtask

  //////////////////////////////////////////////////
  // Fetch and execution side
  //////////////////////////////////////////////////

  task automatic make_pair(int c, bit random_srcs);
    for (int s = 0; s < 2; s++)
    begin
      drv[s].ir    = $random(seed);
      drv[s].npc   = {$random(seed), $random(seed)};
      drv[s].pdest = IDX_W'($random(seed));
      drv[s].ra    = random_srcs ? IDX_W'($random(seed) & 7) : IDX_W'(tab[c][1 + 2*s]);
      drv[s].rb    = random_srcs ? IDX_W'($random(seed) & 7) : IDX_W'(tab[c][2 + 2*s]);
      drv[s].alu   = 5'($random(seed));
      drv[s].rd    = 1'($random(seed));
      drv[s].wr    = 1'($random(seed));
      in_ir[s]       = drv[s].ir;
      in_npc[s]      = drv[s].npc;
      in_pdest[s]    = drv[s].pdest;
      in_prega[s]    = drv[s].ra;
      in_pregb[s]    = drv[s].rb;
      in_alu_func[s] = drv[s].alu;
      in_rd_mem[s]   = drv[s].rd;
      in_wr_mem[s]   = drv[s].wr;
    end
  endtask

  task automatic run_case(int c);
    int waited;
    case_label = case_name[c];
    // Preload writes share the cycle that raises the request
    make_pair(c, 1'b0);
    in_valid = 2'(tab[c][0]);
    in_req   = 1'b1;
    for (int p = 0; p < 2; p++)
    begin
      wb_valid[p] = (tab[c][5 + p] != 0);
      wb_tag[p]   = IDX_W'(tab[c][5 + p]);
      wb_value[p] = {$random(seed), $random(seed)};
    end
    model_cycle();
    waited = 0;
    forever
    begin
      tick();
      wb_valid = '0;
      if (in_ack)
        break;
      waited++;
      if (waited >= TIMEOUT)
      begin
        timeouts++;
        $display("%s: fetch request was not acknowledged in time", case_label);
        return;
      end
      model_cycle();
    end
    for (int k = 0; k < 4; k++)
    begin
      if (k > 0)
        tick();
      if (in_req && in_ack)
        in_req = 1'b0;
      if (k == tab[c][16])
      begin
        make_pair(c, 1'b1);  // Second request while the slots are full
        in_valid = 2'b11;
        in_req   = 1'b1;
      end
      window_free = 2'(tab[c][7 + k]);
      wb_valid    = (k == tab[c][14]) ? 2'(tab[c][11]) : 2'b00;
      wb_tag[0]   = IDX_W'(tab[c][12]);
      wb_tag[1]   = IDX_W'(tab[c][13]);
      wb_value[0] = {$random(seed), $random(seed)};
      wb_value[1] = {$random(seed), $random(seed)};
      flush       = (k == tab[c][15]);
      model_cycle();
    end
    // Drain until the slots, the handshake and the outputs are idle
    waited = 0;
    forever
    begin
      tick();
      if (pend_cnt == 0 && !in_req && !in_ack && iss_valid == '0)
        break;
      waited++;
      if (waited >= TIMEOUT)
      begin
        timeouts++;
        $display("%s: buffer or handshake did not return to idle in time", case_label);
        return;
      end
      window_free = 2'd2;
      wb_valid    = '0;
      flush       = 1'b0;
      if (in_req && in_ack)
        in_req = 1'b0;
      model_cycle();
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    seed        = 49;
    mismatches  = 0;
    timeouts    = 0;
    case_label  = "reset";
    arst_n      = 1'b0;
    flush       = 1'b0;
    in_req      = 1'b0;
    in_valid    = '0;
    in_ir       = '0;
    in_npc      = '0;
    in_pdest    = '0;
    in_prega    = '0;
    in_pregb    = '0;
    in_alu_func = '0;
    in_rd_mem   = '0;
    in_wr_mem   = '0;
    window_free = 2'd2;
    wb_valid    = '0;
    wb_tag      = '0;
    wb_value    = '0;
    for (int r = 0; r < NUM_PREGS; r++)
      model_reg[r] = '0;
    pend_cnt  = 0;
    exp_ack   = 1'b0;
    exp_valid = '0;

    repeat (10) @(posedge clock);
    #1 arst_n = 1'b1;
    check_value("in_ack", 64'(1'b0), 64'(in_ack));
    check_value("iss_valid", 64'(2'b00), 64'(iss_valid));
    check_value("iss_ir[0]", 64'(dispatch_pkg::NOOP_INST), 64'(iss_ir[0]));
    check_value("iss_ir[1]", 64'(dispatch_pkg::NOOP_INST), 64'(iss_ir[1]));

    for (int c = 0; c < NUM_CASES; c++)
    begin
      run_case(c);
      if (timeouts != 0)
        break;
    end

    $display("Closing: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

/* dispatch_top.sv */
/*
  Two-wide dispatch front: the dispatch buffer feeds the issue stage, which
  reads its operands from the physical register file with CDB forwarding.
*/

`timescale 1ns/1ns

module dispatch_top #(
  parameter  int NUM_PREGS = dispatch_pkg::DEFAULT_NUM_PREGS,
  localparam int IDX_W     = $clog2(NUM_PREGS)
) (
  input  logic                                                 clock,
  input  logic                                                 arst_n,
  input  logic                                                 flush,

  // Intake from fetch, four-phase req/ack
  input  logic                                                 in_req,
  output logic                                                 in_ack,
  input  logic [dispatch_pkg::WAYS-1:0]                        in_valid,
  input  dispatch_pkg::inst_word_t [dispatch_pkg::WAYS-1:0]    in_ir,
  input  dispatch_pkg::npc_t [dispatch_pkg::WAYS-1:0]          in_npc,
  input  logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]             in_pdest,
  input  logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]             in_prega,
  input  logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]             in_pregb,
  input  dispatch_pkg::alu_func_t [dispatch_pkg::WAYS-1:0]     in_alu_func,
  input  logic [dispatch_pkg::WAYS-1:0]                        in_rd_mem,
  input  logic [dispatch_pkg::WAYS-1:0]                        in_wr_mem,

  // Window occupancy
  input  dispatch_pkg::free_count_t                            window_free,

  // CDB writeback
  input  logic [dispatch_pkg::WAYS-1:0]                        wb_valid,
  input  logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]             wb_tag,
  input  dispatch_pkg::word_t [dispatch_pkg::WAYS-1:0]         wb_value,

  // Issued instructions
  output logic [dispatch_pkg::WAYS-1:0]                        iss_valid,
  output dispatch_pkg::inst_word_t [dispatch_pkg::WAYS-1:0]    iss_ir,
  output dispatch_pkg::npc_t [dispatch_pkg::WAYS-1:0]          iss_npc,
  output logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]             iss_pdest,
  output dispatch_pkg::alu_func_t [dispatch_pkg::WAYS-1:0]     iss_alu_func,
  output logic [dispatch_pkg::WAYS-1:0]                        iss_rd_mem,
  output logic [dispatch_pkg::WAYS-1:0]                        iss_wr_mem,
  output dispatch_pkg::word_t [dispatch_pkg::WAYS-1:0]         iss_rega_value,
  output dispatch_pkg::word_t [dispatch_pkg::WAYS-1:0]         iss_regb_value
);

  // Buffer to issue stage
  logic [dispatch_pkg::WAYS-1:0]                       issue_go;
  dispatch_pkg::inst_word_t [dispatch_pkg::WAYS-1:0]   slot_ir;
  dispatch_pkg::npc_t [dispatch_pkg::WAYS-1:0]         slot_npc;
  logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]            slot_pdest;
  logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]            slot_prega;
  logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]            slot_pregb;
  dispatch_pkg::alu_func_t [dispatch_pkg::WAYS-1:0]    slot_alu_func;
  logic [dispatch_pkg::WAYS-1:0]                       slot_rd_mem;
  logic [dispatch_pkg::WAYS-1:0]                       slot_wr_mem;

  // Register file read data, prega then pregb per slot
  dispatch_pkg::word_t [2*dispatch_pkg::WAYS-1:0]      rd_value;

  dispatch_buffer #(.NUM_PREGS(NUM_PREGS)) i_dispatch_buffer (
    .clock, .arst_n, .flush,
    .in_req, .in_ack, .in_valid, .in_ir, .in_npc, .in_pdest,
    .in_prega, .in_pregb, .in_alu_func, .in_rd_mem, .in_wr_mem,
    .window_free,
    .issue_go, .slot_ir, .slot_npc, .slot_pdest, .slot_prega,
    .slot_pregb, .slot_alu_func, .slot_rd_mem, .slot_wr_mem
  );

  phys_regfile #(.NUM_PREGS(NUM_PREGS)) i_phys_regfile (
    .clock, .arst_n,
    .wb_valid, .wb_tag, .wb_value,
    .rd_idx   ({slot_pregb[1], slot_prega[1], slot_pregb[0], slot_prega[0]}),
    .rd_value (rd_value)
  );

  issue_stage #(.NUM_PREGS(NUM_PREGS)) i_issue_stage (
    .clock, .arst_n, .flush,
    .issue_go, .slot_ir, .slot_npc, .slot_pdest, .slot_prega,
    .slot_pregb, .slot_alu_func, .slot_rd_mem, .slot_wr_mem,
    .rd_value,
    .wb_valid, .wb_tag, .wb_value,
    .iss_valid, .iss_ir, .iss_npc, .iss_pdest, .iss_alu_func,
    .iss_rd_mem, .iss_wr_mem, .iss_rega_value, .iss_regb_value
  );

endmodule

/* issue_stage.sv */
/*
  Issue stage. Forwards CDB values into the source operands of the slots
  that go this cycle and holds them in the issue register for one cycle.
*/

`timescale 1ns/1ns

module issue_stage #(
  parameter  int NUM_PREGS = dispatch_pkg::DEFAULT_NUM_PREGS,
  localparam int IDX_W     = $clog2(NUM_PREGS)
) (
  input  logic                                              clock,
  input  logic                                              arst_n,
  input  logic                                              flush,

  // From the dispatch buffer
  input  logic [dispatch_pkg::WAYS-1:0]                     issue_go,
  input  dispatch_pkg::inst_word_t [dispatch_pkg::WAYS-1:0] slot_ir,
  input  dispatch_pkg::npc_t [dispatch_pkg::WAYS-1:0]       slot_npc,
  input  logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]          slot_pdest,
  input  logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]          slot_prega,
  input  logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]          slot_pregb,
  input  dispatch_pkg::alu_func_t [dispatch_pkg::WAYS-1:0]  slot_alu_func,
  input  logic [dispatch_pkg::WAYS-1:0]                     slot_rd_mem,
  input  logic [dispatch_pkg::WAYS-1:0]                     slot_wr_mem,

  input  dispatch_pkg::word_t [2*dispatch_pkg::WAYS-1:0]    rd_value,

  input  logic [dispatch_pkg::WAYS-1:0]                     wb_valid,
  input  logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]          wb_tag,
  input  dispatch_pkg::word_t [dispatch_pkg::WAYS-1:0]      wb_value,

  output logic [dispatch_pkg::WAYS-1:0]                     iss_valid,
  output dispatch_pkg::inst_word_t [dispatch_pkg::WAYS-1:0] iss_ir,
  output dispatch_pkg::npc_t [dispatch_pkg::WAYS-1:0]       iss_npc,
  output logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]          iss_pdest,
  output dispatch_pkg::alu_func_t [dispatch_pkg::WAYS-1:0]  iss_alu_func,
  output logic [dispatch_pkg::WAYS-1:0]                     iss_rd_mem,
  output logic [dispatch_pkg::WAYS-1:0]                     iss_wr_mem,
  output dispatch_pkg::word_t [dispatch_pkg::WAYS-1:0]      iss_rega_value,
  output dispatch_pkg::word_t [dispatch_pkg::WAYS-1:0]      iss_regb_value
);

  logic [2*dispatch_pkg::WAYS-1:0][IDX_W-1:0]     src_idx;   // Same order as rd_value
  dispatch_pkg::word_t [2*dispatch_pkg::WAYS-1:0] op_value;

  //////////////////////////////////////////////////
  // CDB forwarding
  //////////////////////////////////////////////////

  for (genvar s = 0; s < dispatch_pkg::WAYS; s++)
  begin : g_src
    assign src_idx[2*s]   = slot_prega[s];
    assign src_idx[2*s+1] = slot_pregb[s];
  end

  always_comb
  begin
    for (int i = 0; i < 2*dispatch_pkg::WAYS; i++)
    begin
      op_value[i] = rd_value[i];
      // Port 1 checked last and so takes priority
      for (int p = 0; p < dispatch_pkg::WAYS; p++)
      begin
        if (wb_valid[p] && wb_tag[p] == src_idx[i] && src_idx[i] != '0)
          op_value[i] = wb_value[p];
      end
    end
  end

  //////////////////////////////////////////////////
  // Issue register
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      iss_valid <= '0;
      iss_ir    <= {dispatch_pkg::WAYS{dispatch_pkg::NOOP_INST}};
    end
    else if (flush)
    begin
      iss_valid <= '0;   // Mispredict kills what is in flight here
      iss_ir    <= {dispatch_pkg::WAYS{dispatch_pkg::NOOP_INST}};
    end
    else
    begin
      for (int s = 0; s < dispatch_pkg::WAYS; s++)
      begin
        iss_valid[s] <= issue_go[s];
        iss_ir[s]    <= issue_go[s] ? slot_ir[s] : dispatch_pkg::NOOP_INST;
      end
    end
  end

  // Operands and decoded fields, only meaningful with iss_valid
  always_ff @(posedge clock)
  begin
    for (int s = 0; s < dispatch_pkg::WAYS; s++)
    begin
      if (issue_go[s])
      begin
        iss_npc[s]        <= slot_npc[s];
        iss_pdest[s]      <= slot_pdest[s];
        iss_alu_func[s]   <= slot_alu_func[s];
        iss_rd_mem[s]     <= slot_rd_mem[s];
        iss_wr_mem[s]     <= slot_wr_mem[s];
        iss_rega_value[s] <= op_value[2*s];
        iss_regb_value[s] <= op_value[2*s+1];
      end
    end
  end

endmodule

/* dispatch_buffer.sv */
/*
  Two-slot dispatch buffer. Takes a renamed pair over a four-phase handshake
  and issues as many slots as the window has room for, oldest first.
*/

`timescale 1ns/1ns

module dispatch_buffer #(
  parameter  int NUM_PREGS = dispatch_pkg::DEFAULT_NUM_PREGS,
  localparam int IDX_W     = $clog2(NUM_PREGS)
) (
  input  logic                                              clock,
  input  logic                                              arst_n,
  input  logic                                              flush,

  input  logic                                              in_req,
  output logic                                              in_ack,
  input  logic [dispatch_pkg::WAYS-1:0]                     in_valid,
  input  dispatch_pkg::inst_word_t [dispatch_pkg::WAYS-1:0] in_ir,
  input  dispatch_pkg::npc_t [dispatch_pkg::WAYS-1:0]       in_npc,
  input  logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]          in_pdest,
  input  logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]          in_prega,
  input  logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]          in_pregb,
  input  dispatch_pkg::alu_func_t [dispatch_pkg::WAYS-1:0]  in_alu_func,
  input  logic [dispatch_pkg::WAYS-1:0]                     in_rd_mem,
  input  logic [dispatch_pkg::WAYS-1:0]                     in_wr_mem,

  input  dispatch_pkg::free_count_t                         window_free,

  output logic [dispatch_pkg::WAYS-1:0]                     issue_go,
  output dispatch_pkg::inst_word_t [dispatch_pkg::WAYS-1:0] slot_ir,
  output dispatch_pkg::npc_t [dispatch_pkg::WAYS-1:0]       slot_npc,
  output logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]          slot_pdest,
  output logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]          slot_prega,
  output logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]          slot_pregb,
  output dispatch_pkg::alu_func_t [dispatch_pkg::WAYS-1:0]  slot_alu_func,
  output logic [dispatch_pkg::WAYS-1:0]                     slot_rd_mem,
  output logic [dispatch_pkg::WAYS-1:0]                     slot_wr_mem
);

  logic [dispatch_pkg::WAYS-1:0]                     slot_valid;
  dispatch_pkg::inst_word_t [dispatch_pkg::WAYS-1:0] ir_q;
  logic capture;  // Pair taken on this edge
  logic shift;    // Slot 1 drops into slot 0
  logic room1;
  logic room2;

  //////////////////////////////////////////////////
  // Issue decision
  //////////////////////////////////////////////////

  assign room1 = (window_free != 2'd0);
  assign room2 = (window_free >= 2'd2);

  // Slot 1 needs two entries only when slot 0 goes ahead of it
  assign issue_go[0] = slot_valid[0] & room1;
  assign issue_go[1] = slot_valid[1] & (slot_valid[0] ? room2 : room1);

  // Almost full case, the older one leaves and the younger moves down
  assign shift = issue_go[0] & ~issue_go[1] & slot_valid[1];

  // Only an empty buffer acknowledges
  assign capture = in_req & ~in_ack & (slot_valid == '0);

  //////////////////////////////////////////////////
  // Handshake and occupancy
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      in_ack     <= 1'b0;
      slot_valid <= '0;
    end
    else
    begin
      if (capture)
        in_ack <= 1'b1;
      else if (!in_req)
        in_ack <= 1'b0;    // Fetch has let go

      if (flush)
        slot_valid <= '0;  // Also drops a pair captured this edge
      else if (capture)
        slot_valid <= in_valid;
      else if (shift)
        slot_valid <= 2'b01;
      else
        slot_valid <= slot_valid & ~issue_go;
    end
  end

  //////////////////////////////////////////////////
  // Slot payload
  //////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (capture)
    begin
      ir_q          <= in_ir;
      slot_npc      <= in_npc;
      slot_pdest    <= in_pdest;
      slot_prega    <= in_prega;
      slot_pregb    <= in_pregb;
      slot_alu_func <= in_alu_func;
      slot_rd_mem   <= in_rd_mem;
      slot_wr_mem   <= in_wr_mem;
    end
    else if (shift)
    begin
      ir_q[0]          <= ir_q[1];
      slot_npc[0]      <= slot_npc[1];
      slot_pdest[0]    <= slot_pdest[1];
      slot_prega[0]    <= slot_prega[1];
      slot_pregb[0]    <= slot_pregb[1];
      slot_alu_func[0] <= slot_alu_func[1];
      slot_rd_mem[0]   <= slot_rd_mem[1];
      slot_wr_mem[0]   <= slot_wr_mem[1];
    end
  end

  // Empty slots present a noop
  for (genvar s = 0; s < dispatch_pkg::WAYS; s++)
  begin : g_slot_ir
    assign slot_ir[s] = slot_valid[s] ? ir_q[s] : dispatch_pkg::NOOP_INST;
  end

endmodule

/* phys_regfile.sv */
/*
  Physical register file, written by both CDB ports and read by four
  combinational ports. Register 0 is hard-wired to zero.
*/

`timescale 1ns/1ns

module phys_regfile #(
  parameter  int NUM_PREGS = dispatch_pkg::DEFAULT_NUM_PREGS,
  localparam int IDX_W     = $clog2(NUM_PREGS)
) (
  input  logic                                           clock,
  input  logic                                           arst_n,

  // CDB write ports
  input  logic [dispatch_pkg::WAYS-1:0]                  wb_valid,
  input  logic [dispatch_pkg::WAYS-1:0][IDX_W-1:0]       wb_tag,
  input  dispatch_pkg::word_t [dispatch_pkg::WAYS-1:0]   wb_value,

  // prega and pregb for each slot
  input  logic [2*dispatch_pkg::WAYS-1:0][IDX_W-1:0]     rd_idx,
  output dispatch_pkg::word_t [2*dispatch_pkg::WAYS-1:0] rd_value
);

  dispatch_pkg::word_t regs [NUM_PREGS];

  //////////////////////////////////////////////////
  // Write
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int r = 0; r < NUM_PREGS; r++)
        regs[r] <= '0;
    end
    else
    begin
      // Later port is applied last so it wins on a shared tag
      for (int p = 0; p < dispatch_pkg::WAYS; p++)
      begin
        if (wb_valid[p] && wb_tag[p] != '0)
          regs[wb_tag[p]] <= wb_value[p];
      end
    end
  end

  //////////////////////////////////////////////////
  // Read
  //////////////////////////////////////////////////

  // No internal bypass here, the issue stage forwards the CDB itself
  always_comb
  begin
    for (int i = 0; i < 2*dispatch_pkg::WAYS; i++)
    begin
      if (rd_idx[i] == '0)
        rd_value[i] = '0;          // Zero register
      else
        rd_value[i] = regs[rd_idx[i]];
    end
  end

endmodule

/* dispatch_pkg.sv */
/*
  Shared widths, field types and reset constants for the dispatch front.
  RTL files refer to these by scoped name.
*/

package dispatch_pkg;

  //////////////////////////////////////////////////
  // Machine width
  //////////////////////////////////////////////////

  // Instructions per pair, also the number of CDB ports
  localparam int WAYS = 2;

  localparam int DATA_W = 64;

  // Default physical register count, overridden at the top level
  localparam int DEFAULT_NUM_PREGS = 64;

  //////////////////////////////////////////////////
  // Field types
  //////////////////////////////////////////////////

  typedef logic [DATA_W-1:0] word_t;      // Register value
  typedef logic [63:0]       npc_t;       // Next PC
  typedef logic [31:0]       inst_word_t; // Raw instruction word
  typedef logic [4:0]        alu_func_t;  // ALU function code

  // Free window entries reported by the window, 0 to 2
  typedef logic [1:0] free_count_t;

  //////////////////////////////////////////////////
  // Reset constants
  //////////////////////////////////////////////////

  // Alpha BIS r31,r31,r31, held by empty slots and an idle issue register
  localparam inst_word_t NOOP_INST = 32'h47ff_041f;

endpackage
